// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/icache_pkg.sv
      - rtl/sync_ram.sv
      - rtl/icache_set_state.sv
      - rtl/icache_ctrl.sv
      - rtl/icache_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - dv/refill_mem_model.sv
      - dv/tb_icache.sv

// ==== dv/icache_vectors.txt ====
// kind address expected_word expected_miss (hex)
// kind 0 fetch, 1 invalidate, 2 memory delay (address = extra cycles), f end
0 00001234 c0de1234 1
0 0000123c c0de123c 0
0 00001230 c0de1230 0
// second tag in set 23
0 00002234 c0de2234 1
0 00001238 c0de1238 0
0 00002238 c0de2238 0
0 00001234 c0de1234 0
0 00002230 c0de2230 0
// lru in set 45, tags A B C
0 00010450 c0df0450 1
0 00020454 c0dc0454 1
0 0001045c c0df045c 0
0 00030458 c0dd0458 1
0 00010454 c0df0454 0
0 0003045c c0dd045c 0
0 00020450 c0dc0450 1
0 00030450 c0dd0450 0
0 00010458 c0df0458 1
// invalidate set 23
1 00000230 00000000 0
0 00001234 c0de1234 1
0 00002238 c0de2238 1
0 00001230 c0de1230 0
0 0000223c c0de223c 0
0 00030454 c0dd0454 0
// slow memory
2 00000010 00000000 0
0 000407f8 c0da07f8 1
0 000407f0 c0da07f0 0
0 000517f4 c0db17f4 1
0 000407fc c0da07fc 0
0 00000800 c0de0800 1
2 00000000 00000000 0
0 00000804 c0de0804 0
0 0000fff0 c0defff0 1
f 00000000 00000000 0

// ==== dv/refill_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module refill_mem_model #(
    parameter int unsigned       seed     = 1,
    parameter icache_pkg::word_t line_key = '0
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              rd_req,
    input  wire icache_pkg::addr_t rd_addr,
    input  wire logic [7:0]        extra_delay,
    output logic                   rd_rdy,
    output logic                   ret_valid,
    output icache_pkg::line_t      ret_data
);

    import icache_pkg::*;

    int unsigned wait_cycles;
    addr_t       req_addr;

    // word k of a line is its byte address xor the key
    function automatic line_t make_line(input addr_t line_addr);
        line_t l;
        for (int k = 0; k < `ICACHE_WORDS_PER_LINE; k++) begin
            l[k*$bits(word_t) +: $bits(word_t)] = (line_addr + addr_t'(4 * k)) ^ line_key;
        end
        return l;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        void'($urandom(seed));
        forever begin
            next_cycle();
            if (!reset && rd_req) begin
                wait_cycles = 32'(extra_delay) + ($urandom % 6);
                repeat (wait_cycles) next_cycle();
                rd_rdy   = 1'b1; // request taken this cycle
                req_addr = rd_addr;
                next_cycle();
                rd_rdy      = 1'b0;
                wait_cycles = 32'(extra_delay) + ($urandom % 6);
                repeat (wait_cycles) next_cycle();
                ret_valid = 1'b1;
                ret_data  = make_line(req_addr);
                next_cycle();
                ret_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    import icache_pkg::*;

    localparam int unsigned seed     = 32'h1522_e893;
    localparam word_t       line_key = 32'hc0de_0000;
    localparam int          timeout  = 200; // cycles per fetch
    localparam int          max_vec  = 64;

    localparam logic [31:0] kind_fetch = 32'h0;
    localparam logic [31:0] kind_inv   = 32'h1;
    localparam logic [31:0] kind_delay = 32'h2; // memory slowdown in cycles

    logic        clk = 1'b0;
    logic        reset;
    logic        fetch_valid;
    logic        inv_valid;
    addr_t       fetch_addr;
    logic        busy;
    word_t       rdata;
    logic        rd_req;
    addr_t       rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    line_t       ret_data;
    logic [7:0]  extra_delay;

    logic [31:0] vec [max_vec*4];
    int          idx;
    int          n_ops;
    int          n_checks;
    int          errors;
    logic        timed_out;
    logic        op_ok;
    logic        done;

    always #10 clk = ~clk;

    icache_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .inv_valid   (inv_valid),
        .fetch_addr  (fetch_addr),
        .busy        (busy),
        .rdata       (rdata),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data)
    );

    refill_mem_model #(
        .seed     (seed),
        .line_key (line_key)
    ) mem_i (
        .clk         (clk),
        .reset       (reset),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .extra_delay (extra_delay),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data)
    );

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic run_fetch(input addr_t addr, input word_t exp_word, input logic exp_miss,
                             output logic ok);
        logic  saw_req;
        logic  addr_bad;
        logic  first_busy;
        int    cycles;
        addr_t line_addr;
        saw_req     = 1'b0;
        addr_bad    = 1'b0;
        cycles      = 0;
        line_addr   = {addr[31:4], 4'h0};
        ok          = 1'b1;
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        next_cycle();
        fetch_valid = 1'b0;
        first_busy  = busy;
        while (busy && cycles < timeout) begin
            if (rd_req) begin
                saw_req = 1'b1;
                if (rd_addr !== line_addr && !addr_bad) begin // also catches a moving rd_addr
                    $display("ERROR %0t rd_addr: got %h expected %h", $time, rd_addr, line_addr);
                    addr_bad = 1'b1;
                    errors++;
                    ok = 1'b0;
                end
            end
            next_cycle();
            cycles++;
        end
        if (busy) begin
            $display("timeout: busy still high %0d cycles after fetch of %h", timeout, addr);
            timed_out = 1'b1;
            errors++;
            ok = 1'b0;
        end else begin
            n_checks += 3;
            if (!exp_miss && first_busy) begin
                $display("ERROR %0t busy: got 1 expected 0", $time);
                errors++;
                ok = 1'b0;
            end
            if (saw_req !== exp_miss) begin
                $display("ERROR %0t rd_req seen: got %b expected %b", $time, saw_req, exp_miss);
                errors++;
                ok = 1'b0;
            end
            if (rdata !== exp_word) begin
                $display("ERROR %0t rdata: got %h expected %h", $time, rdata, exp_word);
                errors++;
                ok = 1'b0;
            end
        end
    endtask

    // no response, busy must stay low
    task automatic run_invalidate(input addr_t addr, output logic ok);
        ok         = 1'b1;
        inv_valid  = 1'b1;
        fetch_addr = addr;
        next_cycle();
        inv_valid  = 1'b0;
        n_checks++;
        if (busy !== 1'b0) begin
            $display("ERROR %0t busy: got %b expected 0", $time, busy);
            errors++;
            ok = 1'b0;
        end
    endtask

    initial begin
        reset       = 1'b1;
        fetch_valid = 1'b0;
        inv_valid   = 1'b0;
        fetch_addr  = '0;
        extra_delay = '0;
        n_ops       = 0;
        n_checks    = 0;
        errors      = 0;
        timed_out   = 1'b0;
        done        = 1'b0;
        idx         = 0;
        $readmemh("dv/icache_vectors.txt", vec);
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();
        while (!done) begin
            case (vec[idx*4])
                kind_fetch: begin
                    run_fetch(vec[idx*4+1], vec[idx*4+2], vec[idx*4+3][0], op_ok);
                    $display("op %0d fetch %h %s: %s", idx, vec[idx*4+1],
                             vec[idx*4+3][0] ? "miss" : "hit", op_ok ? "pass" : "fail");
                    n_ops++;
                end
                kind_inv: begin
                    run_invalidate(vec[idx*4+1], op_ok);
                    $display("op %0d invalidate %h: %s", idx, vec[idx*4+1],
                             op_ok ? "pass" : "fail");
                    n_ops++;
                end
                kind_delay: begin
                    extra_delay = vec[idx*4+1][7:0];
                    $display("op %0d memory delay now %0d extra cycles", idx, extra_delay);
                end
                default: done = 1'b1; // end marker
            endcase
            idx++;
            if (idx >= max_vec || timed_out) begin
                done = 1'b1;
            end
        end
        if (n_ops == 0) begin
            $display("no operations read from the vector file");
            errors++;
        end
        $display("%0d operations, %0d checks, %0d errors", n_ops, n_checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_ctrl (
    input  wire logic                                   clk,
    input  wire logic                                   reset,
    // cpu side
    input  wire logic                                   fetch_valid,
    input  wire logic                                   inv_valid,
    input  wire icache_pkg::addr_t                      fetch_addr,
    output logic                                        busy,
    output icache_pkg::word_t                           rdata,
    // memory side
    output logic                                        rd_req,
    output icache_pkg::addr_t                           rd_addr,
    input  wire logic                                   rd_rdy,
    input  wire logic                                   ret_valid,
    input  wire icache_pkg::line_t                      ret_data,
    // arrays
    output icache_pkg::index_t                          ram_index,
    input  wire icache_pkg::tag_t [`ICACHE_WAYS-1:0]    tag_rdata,
    output icache_pkg::way_mask_t                       tag_we,
    output icache_pkg::tag_t                            tag_wdata,
    input  wire icache_pkg::word_t [`ICACHE_WAYS-1:0][`ICACHE_WORDS_PER_LINE-1:0] bank_rdata,
    output icache_pkg::way_mask_t                       bank_we,
    output icache_pkg::word_t [`ICACHE_WORDS_PER_LINE-1:0] bank_wdata,
    // set state
    input  wire icache_pkg::way_mask_t                  valid,
    input  wire icache_pkg::way_t                       victim,
    output logic                                        fill,
    output logic                                        touch,
    output logic                                        clear,
    output icache_pkg::way_t                            fill_way,
    output icache_pkg::way_t                            touch_way,
    output icache_pkg::index_t                          wr_index
);

    import icache_pkg::*;

    typedef enum logic [1:0] {
        LOOKUP,
        MISS,
        REFILL,
        REFILL_DONE
    } state_t;

    state_t    state;
    state_t    state_nxt;
    logic      lookup_pend; // compare due this cycle
    tag_t      buf_tag;
    index_t    buf_index;
    word_sel_t buf_sel;
    way_t      victim_q;
    way_mask_t hit;
    way_t      hit_way;
    logic      cache_hit;
    logic      accept;
    logic      inv_accept;
    logic      refill_wr;
    tag_t      fetch_tag;
    index_t    fetch_index;

    assign fetch_tag   = fetch_addr[$bits(addr_t)-1 -: $bits(tag_t)];
    assign fetch_index = fetch_addr[offset_bits +: $bits(index_t)];

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_cmp
        assign hit[w] = valid[w] && (tag_rdata[w] == buf_tag);
    end

    assign cache_hit = |hit;
    assign hit_way   = hit[1] ? way_t'(1) : way_t'(0);
    assign rdata     = bank_rdata[hit_way][buf_sel];

    // busy rises straight from a failed compare
    always_comb begin
        busy = 1'b1;
        if (state == LOOKUP) begin
            busy = lookup_pend && !cache_hit;
        end
    end

    assign accept     = fetch_valid && !busy;
    assign inv_accept = inv_valid && !busy;

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_tag   <= fetch_tag;
            buf_index <= fetch_index;
            buf_sel   <= fetch_addr[byte_bits +: $bits(word_sel_t)];
        end
    end

    // victim output tracks the buffered set while waiting on memory
    always_ff @(posedge clk) begin
        if (state == MISS) begin
            victim_q <= victim;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= LOOKUP;
            lookup_pend <= 1'b0;
        end else begin
            state       <= state_nxt;
            lookup_pend <= accept || (state == REFILL_DONE); // re-check after fill
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            LOOKUP: begin
                if (lookup_pend && !cache_hit) begin
                    state_nxt = MISS;
                end
            end
            MISS: begin
                if (rd_rdy) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    state_nxt = REFILL_DONE;
                end
            end
            REFILL_DONE: state_nxt = LOOKUP;
            default:     state_nxt = LOOKUP;
        endcase
    end

    assign rd_req  = (state == MISS);
    assign rd_addr = {buf_tag, buf_index, {offset_bits{1'b0}}}; // line aligned

    // buffered set unless a new fetch is taken
    assign ram_index = (state == LOOKUP && accept) ? fetch_index : buf_index;

    assign refill_wr  = (state == REFILL) && ret_valid;
    assign tag_we     = refill_wr ? way_mask_t'(1) << victim_q : '0;
    assign bank_we    = tag_we;
    assign tag_wdata  = buf_tag;
    assign bank_wdata = ret_data;

    assign fill      = refill_wr;
    assign fill_way  = victim_q;
    assign touch     = (state == LOOKUP) && lookup_pend && cache_hit && !inv_accept;
    assign touch_way = hit_way;
    assign clear     = inv_accept;
    assign wr_index  = inv_accept ? fetch_index : buf_index;

    no_fetch_busy_a: assert property (
        @(posedge clk) disable iff (reset) fetch_valid |-> !busy
    );

    fetch_inv_excl_a: assert property (
        @(posedge clk) disable iff (reset) !(fetch_valid && inv_valid)
    );

    // line address held until the memory takes it
    rd_addr_hold_a: assert property (
        @(posedge clk) disable iff (reset) rd_req && !rd_rdy |=> rd_req && $stable(rd_addr)
    );

    // a tag is only filled after missing in both ways
    one_hit_a: assert property (@(posedge clk) disable iff (reset) $onehot0(hit));

endmodule

`default_nettype wire

// ==== rtl/icache_macros.svh ====
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// cache geometry, two ways of 4 KiB each

`define ICACHE_WAYS 2

// sets per way
`define ICACHE_SETS 256

`define ICACHE_WORDS_PER_LINE 4 // 16-byte line

// instruction word width
`define ICACHE_WORD_BITS 32

`endif

// ==== rtl/icache_pkg.sv ====
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

    // address field widths
    localparam int byte_bits   = $clog2(`ICACHE_WORD_BITS / 8);
    localparam int sel_bits    = $clog2(`ICACHE_WORDS_PER_LINE);
    localparam int offset_bits = sel_bits + byte_bits;
    localparam int index_bits  = $clog2(`ICACHE_SETS);

    typedef logic [31:0] addr_t;
    typedef logic [`ICACHE_WORD_BITS-1:0] word_t;

    // word 0 in the low bits
    typedef logic [`ICACHE_WORDS_PER_LINE*`ICACHE_WORD_BITS-1:0] line_t;

    typedef logic [$bits(addr_t)-index_bits-offset_bits-1:0] tag_t; // addr[31:12]
    typedef logic [index_bits-1:0] index_t;                         // addr[11:4]
    typedef logic [sel_bits-1:0] word_sel_t;                        // addr[3:2]

    typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;
    typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

endpackage

`default_nettype wire

// ==== rtl/icache_set_state.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_set_state (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire icache_pkg::index_t rd_index,
    output icache_pkg::way_mask_t   valid,
    output icache_pkg::way_t        victim,
    input  wire logic               fill,
    input  wire icache_pkg::way_t   fill_way,
    input  wire logic               touch,
    input  wire icache_pkg::way_t   touch_way,
    input  wire logic               clear,
    input  wire icache_pkg::index_t wr_index
);

    import icache_pkg::*;

    way_mask_t valid_q [`ICACHE_SETS];
    way_t      lru_q   [`ICACHE_SETS]; // names the next victim

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_q[s] <= '0;
                lru_q[s]   <= '0;
            end
            valid  <= '0;
            victim <= '0;
        end else begin
            valid  <= valid_q[rd_index]; // pre-write value
            victim <= lru_q[rd_index];
            if (clear) begin
                valid_q[wr_index] <= '0;
            end else if (fill) begin
                valid_q[wr_index][fill_way] <= 1'b1;
            end
            // two ways, so the other way is the complement
            if (fill) begin
                lru_q[wr_index] <= way_t'(~fill_way);
            end else if (touch) begin
                lru_q[wr_index] <= way_t'(~touch_way);
            end
        end
    end

    // refill only runs while busy, invalidate only while idle
    fill_clear_a: assert property (@(posedge clk) disable iff (reset) !(fill && clear));

endmodule

`default_nettype wire

// ==== rtl/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_top (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              fetch_valid,
    input  wire logic              inv_valid,
    input  wire icache_pkg::addr_t fetch_addr,
    output logic                   busy,
    output icache_pkg::word_t      rdata,
    output logic                   rd_req,
    output icache_pkg::addr_t      rd_addr,
    input  wire logic              rd_rdy,
    input  wire logic              ret_valid,
    input  wire icache_pkg::line_t ret_data
);

    import icache_pkg::*;

    index_t    ram_index;
    tag_t      [`ICACHE_WAYS-1:0] tag_rdata;
    way_mask_t tag_we;
    tag_t      tag_wdata;
    word_t     [`ICACHE_WAYS-1:0][`ICACHE_WORDS_PER_LINE-1:0] bank_rdata;
    way_mask_t bank_we;
    word_t     [`ICACHE_WORDS_PER_LINE-1:0] bank_wdata;
    way_mask_t valid;
    way_t      victim;
    logic      fill;
    logic      touch;
    logic      clear;
    way_t      fill_way;
    way_t      touch_way;
    index_t    wr_index;

    icache_ctrl ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .inv_valid   (inv_valid),
        .fetch_addr  (fetch_addr),
        .busy        (busy),
        .rdata       (rdata),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data),
        .ram_index   (ram_index),
        .tag_rdata   (tag_rdata),
        .tag_we      (tag_we),
        .tag_wdata   (tag_wdata),
        .bank_rdata  (bank_rdata),
        .bank_we     (bank_we),
        .bank_wdata  (bank_wdata),
        .valid       (valid),
        .victim      (victim),
        .fill        (fill),
        .touch       (touch),
        .clear       (clear),
        .fill_way    (fill_way),
        .touch_way   (touch_way),
        .wr_index    (wr_index)
    );

    icache_set_state set_state_i (
        .clk       (clk),
        .reset     (reset),
        .rd_index  (ram_index),
        .valid     (valid),
        .victim    (victim),
        .fill      (fill),
        .fill_way  (fill_way),
        .touch     (touch),
        .touch_way (touch_way),
        .clear     (clear),
        .wr_index  (wr_index)
    );

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        sync_ram #(
            .payload_t (tag_t),
            .depth     (`ICACHE_SETS)
        ) tag_ram_i (
            .clk   (clk),
            .we    (tag_we[w]),
            .addr  (ram_index),
            .wdata (tag_wdata),
            .rdata (tag_rdata[w])
        );

        // one bank per word of the line
        for (genvar b = 0; b < `ICACHE_WORDS_PER_LINE; b++) begin : g_bank
            sync_ram #(
                .payload_t (word_t),
                .depth     (`ICACHE_SETS)
            ) bank_ram_i (
                .clk   (clk),
                .we    (bank_we[w]),
                .addr  (ram_index),
                .wdata (bank_wdata[b]),
                .rdata (bank_rdata[w][b])
            );
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sync_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 256
) (
    input  wire logic                     clk,
    input  wire logic                     we,
    input  wire logic [$clog2(depth)-1:0] addr,
    input  wire payload_t                 wdata,
    output payload_t                      rdata
);

    payload_t mem [depth]; // validity is tracked outside

    // single port, read returns the old word on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

    // once the write enable is driven it stays known
    we_known_a: assert property (
        @(posedge clk) !$isunknown($past(we)) |-> !$isunknown(we)
    );

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/icache_pkg.sv
rtl/sync_ram.sv
rtl/icache_set_state.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
dv/refill_mem_model.sv
dv/tb_icache.sv
